// ==== rtl/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// ==================================================
// Datapath widths
// ==================================================
`define CPU_DATA_W     8            // One byte on the internal bus
`define CPU_ADDR_W     16           // PC and MAR width

// ==================================================
// Memory map and sequencing
// ==================================================
`define CPU_RAM_DEPTH  256          // Address truncated to its low byte
`define CPU_ORIGIN     16'h0000     // PC value after S_INIT
`define CPU_NUM_STEPS  8            // Microsteps available per opcode

// Bit positions inside flags_t
`define CPU_FLAG_Z     0
`define CPU_FLAG_C     1
`define CPU_FLAG_N     2

`endif

// ==== rtl/cpu_pkg.sv ====
`default_nettype none

`include "cpu_consts.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0] data_t;
    typedef logic [`CPU_ADDR_W-1:0] addr_t;
    typedef logic [2:0] flags_t;                                   // N, C, Z
    typedef logic [$clog2(`CPU_NUM_STEPS)-1:0] microstep_t;

    // ==================================================
    // Instruction set
    // ==================================================
    typedef enum logic [`CPU_DATA_W-1:0] {
        NOP   = 8'h00,
        HLT   = 8'h01,
        LDI_A = 8'h02,
        LDI_B = 8'h03,
        LDI_C = 8'h04,
        ADD_B = 8'h05,
        ADD_C = 8'h06,
        ADC_B = 8'h07,
        ADC_C = 8'h08,
        SUB_B = 8'h09,
        SUB_C = 8'h0A,
        SBC_B = 8'h0B,
        SBC_C = 8'h0C,
        INR_A = 8'h0D,
        DCR_A = 8'h0E,
        JMP   = 8'h0F,
        JZ    = 8'h10,
        JNZ   = 8'h11,
        JN    = 8'h12,
        LDA   = 8'h14                                              // 8'h13 left unassigned
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_UNDEFINED = 3'd0,
        ALU_ADD       = 3'd1,
        ALU_ADC       = 3'd2,
        ALU_SUB       = 3'd3,
        ALU_SBC       = 3'd4,
        ALU_INR       = 3'd5,
        ALU_DCR       = 3'd6
    } alu_op_t;

    typedef enum logic [2:0] {
        S_RESET,
        S_INIT,
        S_LATCH_ADDR,
        S_READ_BYTE,
        S_LATCH_BYTE,
        S_CHK_MORE_BYTES,
        S_EXECUTE,
        S_HALT
    } fsm_state_t;

    // ==================================================
    // Control word from control unit to datapath
    // ==================================================
    typedef struct packed {
        logic    load_origin;
        logic    load_mar_pc;
        logic    load_mar_addr_low;
        logic    load_mar_addr_high;
        logic    load_ir;
        logic    load_temp_1;
        logic    load_temp_2;
        logic    load_a;
        logic    load_b;
        logic    load_c;
        logic    pc_enable;
        logic    load_pc_low_byte;
        logic    load_pc_high_byte;
        logic    load_flags;
        logic    load_sets_zn;                                     // Z and N from the bus with C kept
        logic    oe_ram;
        logic    oe_temp_1;
        logic    oe_temp_2;
        logic    oe_alu;
        alu_op_t alu_op;
        logic    alu_src_c;                                        // Operand C instead of B
        logic    check_zero;
        logic    check_not_zero;
        logic    check_carry;
        logic    check_negative;
        logic    last_step;
        logic    halt;
    } control_word_t;

endpackage

`default_nettype wire

// ==== rtl/alu.sv ====
`default_nettype none

`include "cpu_consts.svh"

module alu (
    input  wire cpu_pkg::alu_op_t alu_op,
    input  wire cpu_pkg::data_t   a,
    input  wire cpu_pkg::data_t   operand,
    input  wire                   carry_in,
    output cpu_pkg::data_t        result,
    output logic                  zero,
    output logic                  carry,
    output logic                  negative
);
    import cpu_pkg::*;

    logic [`CPU_DATA_W:0] a_ext;
    logic [`CPU_DATA_W:0] op_ext;
    logic [`CPU_DATA_W:0] cin_ext;
    logic [`CPU_DATA_W:0] sum;                                     // Top bit is carry or borrow

    assign a_ext   = {1'b0, a};
    assign op_ext  = {1'b0, operand};
    assign cin_ext = {{`CPU_DATA_W{1'b0}}, carry_in};

    always_comb begin
        sum   = '0;
        carry = carry_in;                                          // INR/DCR keep it
        case (alu_op)
            ALU_ADD: sum = a_ext + op_ext;
            ALU_ADC: sum = a_ext + op_ext + cin_ext;
            ALU_SUB: sum = a_ext - op_ext;
            ALU_SBC: sum = a_ext - op_ext - cin_ext;
            ALU_INR: sum = a_ext + 1'b1;
            ALU_DCR: sum = a_ext - 1'b1;
            default: carry = 1'b0;
        endcase
        if (alu_op inside {ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC}) begin
            carry = sum[`CPU_DATA_W];
        end
    end

    assign result   = sum[`CPU_DATA_W-1:0];
    assign zero     = (result == '0);
    assign negative = result[`CPU_DATA_W-1];

endmodule

`default_nettype wire

// ==== rtl/control_unit.sv ====
`default_nettype none

`include "cpu_consts.svh"

module control_unit (
    input  wire                    clk,
    input  wire                    reset,
    input  wire cpu_pkg::opcode_t  opcode,
    input  wire cpu_pkg::flags_t   flags,
    output cpu_pkg::control_word_t control_word,
    output logic                   halted
);
    import cpu_pkg::*;

    localparam int NUM_OPCODES = 2 ** `CPU_DATA_W;

    fsm_state_t state;
    fsm_state_t next_state;
    microstep_t step;
    microstep_t next_step;
    logic [1:0] byte_count;                                        // Bytes fetched so far
    logic [1:0] next_byte_count;
    logic [1:0] num_operand_bytes;
    logic       opcode_valid;
    logic       check_jump;
    logic       jump_taken;

    control_word_t microcode_rom [NUM_OPCODES][`CPU_NUM_STEPS];

    // ==================================================
    // Operand count per opcode
    // ==================================================
    always_comb begin
        opcode_valid      = 1'b1;
        num_operand_bytes = 2'd0;
        case (opcode)
            NOP, HLT, ADD_B, ADD_C, ADC_B, ADC_C, SUB_B, SUB_C,
            SBC_B, SBC_C, INR_A, DCR_A: num_operand_bytes = 2'd0;
            LDI_A, LDI_B, LDI_C:        num_operand_bytes = 2'd1;
            JMP, JZ, JNZ, JN, LDA:      num_operand_bytes = 2'd2;
            default:                    opcode_valid = 1'b0;       // Halts after fetch
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_RESET;
            step       <= '0;
            byte_count <= 2'd0;
        end else begin
            state      <= next_state;
            step       <= next_step;
            byte_count <= next_byte_count;
        end
    end

    // ==================================================
    // Fetch and execute sequencing
    // ==================================================
    always_comb begin
        next_state      = state;
        next_step       = step;
        next_byte_count = byte_count;
        control_word    = '0;
        check_jump      = 1'b0;
        jump_taken      = 1'b0;

        case (state)
            S_RESET: next_state = S_INIT;

            S_INIT: begin
                control_word.load_origin = 1'b1;
                next_state = S_LATCH_ADDR;
            end

            S_LATCH_ADDR: begin
                control_word.load_mar_pc = 1'b1;
                next_state = S_READ_BYTE;
            end

            S_READ_BYTE: begin
                control_word.oe_ram = 1'b1;
                next_state = S_LATCH_BYTE;
            end

            S_LATCH_BYTE: begin
                control_word.oe_ram    = 1'b1;
                control_word.pc_enable = 1'b1;
                case (byte_count)
                    2'd0:    control_word.load_ir = 1'b1;
                    2'd1:    control_word.load_temp_1 = 1'b1;
                    default: control_word.load_temp_2 = 1'b1;
                endcase
                next_byte_count = byte_count + 2'd1;
                next_state = S_CHK_MORE_BYTES;
            end

            S_CHK_MORE_BYTES: begin
                if (!opcode_valid) begin
                    next_state = S_HALT;
                end else if (byte_count > num_operand_bytes) begin
                    next_state      = S_EXECUTE;
                    next_step       = '0;
                    next_byte_count = 2'd0;
                end else begin
                    next_state = S_LATCH_ADDR;                     // Next operand byte
                end
            end

            S_EXECUTE: begin
                control_word = microcode_rom[opcode][step];
                check_jump = control_word.check_zero || control_word.check_not_zero ||
                             control_word.check_carry || control_word.check_negative;
                jump_taken = (control_word.check_zero && flags[`CPU_FLAG_Z]) ||
                             (control_word.check_not_zero && !flags[`CPU_FLAG_Z]) ||
                             (control_word.check_carry && flags[`CPU_FLAG_C]) ||
                             (control_word.check_negative && flags[`CPU_FLAG_N]);

                // Failed condition keeps the PC at the byte after the operands
                if (check_jump && !jump_taken) begin
                    control_word.load_pc_low_byte  = 1'b0;
                    control_word.load_pc_high_byte = 1'b0;
                end

                if (control_word.halt) begin
                    next_state = S_HALT;
                end else if (control_word.last_step) begin
                    next_state = S_LATCH_ADDR;
                    next_step  = '0;
                end else begin
                    next_step = step + 1'b1;
                end
            end

            S_HALT: next_state = S_HALT;                           // Only reset leaves

            default: next_state = S_HALT;
        endcase
    end

    assign halted = (state == S_HALT);

    // ==================================================
    // Microcode ROM
    // ==================================================
    function automatic control_word_t alu_step(alu_op_t op, logic src_c, logic commit);
        control_word_t w;
        w            = '0;
        w.alu_op     = op;
        w.alu_src_c  = src_c;
        w.oe_alu     = commit;                                     // A and flags latch together
        w.load_a     = commit;
        w.load_flags = commit;
        w.last_step  = commit;
        return w;
    endfunction

    function automatic control_word_t jump_step(logic high, logic cz, logic cnz, logic cn);
        control_word_t w;
        w                   = '0;
        w.oe_temp_1         = !high;
        w.load_pc_low_byte  = !high;
        w.oe_temp_2         = high;
        w.load_pc_high_byte = high;
        w.last_step         = high;
        w.check_zero        = cz;                                  // Checked on both steps
        w.check_not_zero    = cnz;
        w.check_negative    = cn;
        return w;
    endfunction

    initial begin
        for (int op = 0; op < NUM_OPCODES; op++) begin
            for (int s = 0; s < `CPU_NUM_STEPS; s++) begin
                microcode_rom[op][s] = '0;
            end
        end

        microcode_rom[NOP][0] = '{default: 1'b0, alu_op: ALU_UNDEFINED, last_step: 1'b1};
        microcode_rom[HLT][0] = '{default: 1'b0, alu_op: ALU_UNDEFINED, halt: 1'b1};

        microcode_rom[LDI_A][0] = '{default: 1'b0, alu_op: ALU_UNDEFINED, oe_temp_1: 1'b1,
                                    load_a: 1'b1, load_flags: 1'b1, load_sets_zn: 1'b1,
                                    last_step: 1'b1};
        microcode_rom[LDI_B][0] = '{default: 1'b0, alu_op: ALU_UNDEFINED, oe_temp_1: 1'b1,
                                    load_b: 1'b1, load_flags: 1'b1, load_sets_zn: 1'b1,
                                    last_step: 1'b1};
        microcode_rom[LDI_C][0] = '{default: 1'b0, alu_op: ALU_UNDEFINED, oe_temp_1: 1'b1,
                                    load_c: 1'b1, load_flags: 1'b1, load_sets_zn: 1'b1,
                                    last_step: 1'b1};

        microcode_rom[ADD_B][0] = alu_step(ALU_ADD, 1'b0, 1'b0);
        microcode_rom[ADD_B][1] = alu_step(ALU_ADD, 1'b0, 1'b1);
        microcode_rom[ADD_C][0] = alu_step(ALU_ADD, 1'b1, 1'b0);
        microcode_rom[ADD_C][1] = alu_step(ALU_ADD, 1'b1, 1'b1);
        microcode_rom[ADC_B][0] = alu_step(ALU_ADC, 1'b0, 1'b0);
        microcode_rom[ADC_B][1] = alu_step(ALU_ADC, 1'b0, 1'b1);
        microcode_rom[ADC_C][0] = alu_step(ALU_ADC, 1'b1, 1'b0);
        microcode_rom[ADC_C][1] = alu_step(ALU_ADC, 1'b1, 1'b1);
        microcode_rom[SUB_B][0] = alu_step(ALU_SUB, 1'b0, 1'b0);
        microcode_rom[SUB_B][1] = alu_step(ALU_SUB, 1'b0, 1'b1);
        microcode_rom[SUB_C][0] = alu_step(ALU_SUB, 1'b1, 1'b0);
        microcode_rom[SUB_C][1] = alu_step(ALU_SUB, 1'b1, 1'b1);
        microcode_rom[SBC_B][0] = alu_step(ALU_SBC, 1'b0, 1'b0);
        microcode_rom[SBC_B][1] = alu_step(ALU_SBC, 1'b0, 1'b1);
        microcode_rom[SBC_C][0] = alu_step(ALU_SBC, 1'b1, 1'b0);
        microcode_rom[SBC_C][1] = alu_step(ALU_SBC, 1'b1, 1'b1);
        microcode_rom[INR_A][0] = alu_step(ALU_INR, 1'b0, 1'b0);
        microcode_rom[INR_A][1] = alu_step(ALU_INR, 1'b0, 1'b1);
        microcode_rom[DCR_A][0] = alu_step(ALU_DCR, 1'b0, 1'b0);
        microcode_rom[DCR_A][1] = alu_step(ALU_DCR, 1'b0, 1'b1);

        microcode_rom[JMP][0] = jump_step(1'b0, 1'b0, 1'b0, 1'b0);
        microcode_rom[JMP][1] = jump_step(1'b1, 1'b0, 1'b0, 1'b0);
        microcode_rom[JZ][0]  = jump_step(1'b0, 1'b1, 1'b0, 1'b0);
        microcode_rom[JZ][1]  = jump_step(1'b1, 1'b1, 1'b0, 1'b0);
        microcode_rom[JNZ][0] = jump_step(1'b0, 1'b0, 1'b1, 1'b0);
        microcode_rom[JNZ][1] = jump_step(1'b1, 1'b0, 1'b1, 1'b0);
        microcode_rom[JN][0]  = jump_step(1'b0, 1'b0, 1'b0, 1'b1);
        microcode_rom[JN][1]  = jump_step(1'b1, 1'b0, 1'b0, 1'b1);

        // LDA loads the MAR from both address bytes and then reads the data byte into A
        microcode_rom[LDA][0] = '{default: 1'b0, alu_op: ALU_UNDEFINED, oe_temp_1: 1'b1};
        microcode_rom[LDA][1] = '{default: 1'b0, alu_op: ALU_UNDEFINED, oe_temp_1: 1'b1,
                                  load_mar_addr_low: 1'b1};
        microcode_rom[LDA][2] = '{default: 1'b0, alu_op: ALU_UNDEFINED, oe_temp_2: 1'b1};
        microcode_rom[LDA][3] = '{default: 1'b0, alu_op: ALU_UNDEFINED, oe_temp_2: 1'b1,
                                  load_mar_addr_high: 1'b1};
        microcode_rom[LDA][4] = '{default: 1'b0, alu_op: ALU_UNDEFINED, oe_ram: 1'b1};
        microcode_rom[LDA][5] = '{default: 1'b0, alu_op: ALU_UNDEFINED, oe_ram: 1'b1,
                                  load_a: 1'b1, load_flags: 1'b1, load_sets_zn: 1'b1,
                                  last_step: 1'b1};
    end

endmodule

`default_nettype wire

// ==== rtl/datapath.sv ====
`default_nettype none

`include "cpu_consts.svh"

module datapath (
    input  wire                        clk,
    input  wire                        reset,
    input  wire cpu_pkg::control_word_t control_word,
    input  wire cpu_pkg::data_t        mem_data,
    output cpu_pkg::addr_t             mem_addr,
    output cpu_pkg::opcode_t           opcode,
    output cpu_pkg::flags_t            flags,
    output cpu_pkg::addr_t             pc,
    output cpu_pkg::data_t             reg_a,
    output cpu_pkg::data_t             reg_b,
    output cpu_pkg::data_t             reg_c
);
    import cpu_pkg::*;

    data_t bus;
    data_t temp_1;
    data_t temp_2;
    data_t alu_operand;
    data_t alu_result;
    addr_t mar;
    logic  alu_zero;
    logic  alu_carry;
    logic  alu_negative;

    assign alu_operand = control_word.alu_src_c ? reg_c : reg_b;
    assign mem_addr    = mar;

    alu u_alu (
        .alu_op   (control_word.alu_op),
        .a        (reg_a),
        .operand  (alu_operand),
        .carry_in (flags[`CPU_FLAG_C]),
        .result   (alu_result),
        .zero     (alu_zero),
        .carry    (alu_carry),
        .negative (alu_negative)
    );

    // ==================================================
    // Byte bus with one source per cycle
    // ==================================================
    always_comb begin
        if (control_word.oe_ram)         bus = mem_data;
        else if (control_word.oe_temp_1) bus = temp_1;
        else if (control_word.oe_temp_2) bus = temp_2;
        else if (control_word.oe_alu)    bus = alu_result;
        else                             bus = '0;
    end

    // ==================================================
    // Architectural registers
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            reg_a <= '0;
            reg_b <= '0;
            reg_c <= '0;
            flags <= '0;
            pc    <= '0;
            mar   <= '0;
        end else begin
            if (control_word.load_a) reg_a <= bus;
            if (control_word.load_b) reg_b <= bus;
            if (control_word.load_c) reg_c <= bus;

            if (control_word.load_flags && control_word.load_sets_zn) begin
                flags[`CPU_FLAG_Z] <= (bus == '0);                 // Carry held
                flags[`CPU_FLAG_N] <= bus[`CPU_DATA_W-1];
            end else if (control_word.load_flags) begin
                flags[`CPU_FLAG_Z] <= alu_zero;
                flags[`CPU_FLAG_C] <= alu_carry;
                flags[`CPU_FLAG_N] <= alu_negative;
            end

            if (control_word.load_origin) begin
                pc <= `CPU_ORIGIN;
            end else if (control_word.pc_enable) begin
                pc <= pc + 1'b1;
            end else begin
                if (control_word.load_pc_low_byte)  pc[`CPU_DATA_W-1:0] <= bus;
                if (control_word.load_pc_high_byte) pc[`CPU_ADDR_W-1:`CPU_DATA_W] <= bus;
            end

            if (control_word.load_mar_pc)        mar <= pc;
            if (control_word.load_mar_addr_low)  mar[`CPU_DATA_W-1:0] <= bus;
            if (control_word.load_mar_addr_high) mar[`CPU_ADDR_W-1:`CPU_DATA_W] <= bus;
        end
    end

    // Instruction and operand holding registers
    always_ff @(posedge clk) begin
        if (control_word.load_ir)     opcode <= opcode_t'(bus);
        if (control_word.load_temp_1) temp_1 <= bus;
        if (control_word.load_temp_2) temp_2 <= bus;
    end

endmodule

`default_nettype wire

// ==== rtl/program_ram.sv ====
`default_nettype none

`include "cpu_consts.svh"

module program_ram (
    input  wire                 clk,
    input  wire                 we,
    input  wire cpu_pkg::data_t waddr,
    input  wire cpu_pkg::data_t wdata,
    input  wire cpu_pkg::addr_t raddr,
    output cpu_pkg::data_t      rdata
);
    import cpu_pkg::*;

    localparam int INDEX_W = $clog2(`CPU_RAM_DEPTH);

    data_t mem [`CPU_RAM_DEPTH];                                   // Survives reset

    // Program load port writes one byte per strobe
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr[INDEX_W-1:0]] <= wdata;
        end
    end

    assign rdata = mem[raddr[INDEX_W-1:0]];                        // Upper address bits ignored

endmodule

`default_nettype wire

// ==== rtl/cpu_top.sv ====
`default_nettype none

module cpu_top (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 prog_we,
    input  wire cpu_pkg::data_t prog_addr,
    input  wire cpu_pkg::data_t prog_data,
    output logic                halted,
    output cpu_pkg::addr_t      pc,
    output cpu_pkg::data_t      reg_a,
    output cpu_pkg::data_t      reg_b,
    output cpu_pkg::data_t      reg_c,
    output cpu_pkg::flags_t     flags
);
    import cpu_pkg::*;

    control_word_t control_word;
    opcode_t       opcode;
    addr_t         mem_addr;
    data_t         mem_data;

    control_unit u_control_unit (
        .clk          (clk),
        .reset        (reset),
        .opcode       (opcode),
        .flags        (flags),
        .control_word (control_word),
        .halted       (halted)
    );

    datapath u_datapath (
        .clk          (clk),
        .reset        (reset),
        .control_word (control_word),
        .mem_data     (mem_data),
        .mem_addr     (mem_addr),
        .opcode       (opcode),
        .flags        (flags),
        .pc           (pc),
        .reg_a        (reg_a),
        .reg_b        (reg_b),
        .reg_c        (reg_c)
    );

    program_ram u_program_ram (
        .clk   (clk),
        .we    (prog_we),
        .waddr (prog_addr),
        .wdata (prog_data),
        .raddr (mem_addr),
        .rdata (mem_data)
    );

endmodule

`default_nettype wire

// ==== dv/clock_gen.sv ====
`default_nettype none

module clock_gen (
    output logic clk,
    output logic por                                              // Power-on reset
);
    timeunit 1ns;
    timeprecision 1ns;

    localparam int PERIOD_NS   = 100;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Released on a falling edge like the other inputs
    initial begin
        por = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        por = 1'b0;
    end

endmodule

`default_nettype wire

// ==== dv/cpu_tb.sv ====
`default_nettype none

`include "cpu_consts.svh"

module cpu_tb;
    timeunit 1ns;
    timeprecision 1ns;

    import cpu_pkg::*;

    localparam int NUM_PROGS   = 18;
    localparam int LOAD_CYCLES = 16 + `CPU_RAM_DEPTH + 2 + 20;
    localparam int CYCLE_LIMIT = 12 * 64 * 30 + NUM_PROGS * LOAD_CYCLES;

    logic    clk;
    logic    por;
    logic    hold_reset;
    logic    prog_we;
    data_t   prog_addr;
    data_t   prog_data;
    logic    halted;
    addr_t   pc;
    data_t   reg_a;
    data_t   reg_b;
    data_t   reg_c;
    flags_t  flags;

    data_t   image [`CPU_RAM_DEPTH];
    int      img_len;
    int      seed = 32'h7b42;
    int      errors = 0;
    int      checks = 0;
    int      cycles = 0;
    event    compare_ev;
    string   exp_label;
    logic    exp_halted;
    addr_t   exp_pc;
    data_t   exp_a;
    data_t   exp_b;
    data_t   exp_c;
    flags_t  exp_flags;

    clock_gen u_clock_gen (.clk(clk), .por(por));

    cpu_top u_dut (
        .clk       (clk),
        .reset     (por || hold_reset),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .halted    (halted),
        .pc        (pc),
        .reg_a     (reg_a),
        .reg_b     (reg_b),
        .reg_c     (reg_c),
        .flags     (flags)
    );

    // ==================================================
    // Instruction-set reference model
    // ==================================================
    function automatic void run_model(output data_t a, output data_t b, output data_t c,
                                      output flags_t f, output addr_t pc_out);
        data_t      op;
        data_t      lo;
        data_t      hi;
        logic [8:0] r;
        addr_t      p;
        a = '0;
        b = '0;
        c = '0;
        f = '0;
        p = `CPU_ORIGIN;
        for (int n = 0; n < 1000; n++) begin
            op = image[p[7:0]];
            p  = p + 16'd1;
            if (op inside {8'h02, 8'h03, 8'h04, 8'h0F, 8'h10, 8'h11, 8'h12, 8'h14}) begin
                lo = image[p[7:0]];
                p  = p + 16'd1;
            end
            if (op inside {8'h0F, 8'h10, 8'h11, 8'h12, 8'h14}) begin
                hi = image[p[7:0]];
                p  = p + 16'd1;
            end
            r = {1'b0, a};
            case (op)
                8'h00: ;
                8'h02: r = {1'b0, lo};
                8'h03: r = {1'b0, lo};
                8'h04: r = {1'b0, lo};
                8'h05: r = {1'b0, a} + {1'b0, b};
                8'h06: r = {1'b0, a} + {1'b0, c};
                8'h07: r = {1'b0, a} + {1'b0, b} + {8'd0, f[1]};
                8'h08: r = {1'b0, a} + {1'b0, c} + {8'd0, f[1]};
                8'h09: r = {1'b0, a} - {1'b0, b};
                8'h0A: r = {1'b0, a} - {1'b0, c};
                8'h0B: r = {1'b0, a} - {1'b0, b} - {8'd0, f[1]};
                8'h0C: r = {1'b0, a} - {1'b0, c} - {8'd0, f[1]};
                8'h0D: r = {1'b0, a} + 9'd1;
                8'h0E: r = {1'b0, a} - 9'd1;
                8'h0F: p = {hi, lo};
                8'h10: if (f[0]) p = {hi, lo};
                8'h11: if (!f[0]) p = {hi, lo};
                8'h12: if (f[2]) p = {hi, lo};
                8'h14: r = {1'b0, image[lo]};                    // Only the low byte addresses
                default: break;                                   // HLT and unknown codes stop
            endcase
            if (op inside {[8'h02:8'h0E], 8'h14}) begin
                if (op inside {[8'h05:8'h0C]}) f[1] = r[8];
                f[0] = (r[7:0] == 8'h00);
                f[2] = r[7];
                case (op)
                    8'h03: b = r[7:0];
                    8'h04: c = r[7:0];
                    default: a = r[7:0];
                endcase
            end
        end
        pc_out = p;
    endfunction

    // ==================================================
    // Comparison process
    // ==================================================
    task automatic check_value(string name, logic [15:0] dut, logic [15:0] expected);
        checks++;
        assert (dut === expected) else begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s %s dut=%h expected=%h",
                     $time, exp_label, name, dut, expected);
        end
    endtask

    always @(compare_ev) begin
        check_value("halted", {15'd0, halted}, {15'd0, exp_halted});
        check_value("pc", pc, exp_pc);
        check_value("reg_a", {8'd0, reg_a}, {8'd0, exp_a});
        check_value("reg_b", {8'd0, reg_b}, {8'd0, exp_b});
        check_value("reg_c", {8'd0, reg_c}, {8'd0, exp_c});
        check_value("flags", {13'd0, flags}, {13'd0, exp_flags});
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            errors++;
            $display("Timeout: the CPU did not halt within %0d cycles", CYCLE_LIMIT);
            $display("checks=%0d errors=%0d", checks, errors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ==================================================
    // Program building and running
    // ==================================================
    task automatic emit(data_t value);
        image[img_len[7:0]] = value;
        img_len++;
    endtask

    task automatic new_image();
        for (int i = 0; i < `CPU_RAM_DEPTH; i++) image[i] = 8'h00;
        img_len = 0;
    endtask

    task automatic build_random(int count);
        int   r;
        int   sel;
        new_image();
        for (int k = 0; k < count; k++) begin
            r   = $random(seed);
            sel = (r & 32'h7fff_ffff) % 13;
            emit(8'(sel + 2));                                    // LDI_A through DCR_A
            if (sel < 3) emit(8'($random(seed)));
        end
        emit(HLT);
    endtask

    task automatic build_jump(opcode_t jop, data_t a_value);
        new_image();
        emit(LDI_A);
        emit(a_value);
        emit(jop);
        emit(8'h0A);
        emit(8'h00);
        emit(LDI_B);                                              // Runs when not taken
        emit(8'h11);
        emit(HLT);
        emit(NOP);
        emit(NOP);
        emit(LDI_C);                                              // Jump target 0x0A
        emit(8'h22);
        emit(HLT);
    endtask

    task automatic run_program(string name);
        @(negedge clk);
        hold_reset = 1'b1;
        repeat (16) @(negedge clk);
        while (por) @(negedge clk);
        for (int i = 0; i < `CPU_RAM_DEPTH; i++) begin
            prog_we   = 1'b1;
            prog_addr = 8'(i);
            prog_data = image[i];
            @(negedge clk);
        end
        prog_we    = 1'b0;
        hold_reset = 1'b0;
        @(negedge clk);
        exp_label  = {name, " reset"};
        exp_halted = 1'b0;
        exp_pc     = '0;
        exp_a      = '0;
        exp_b      = '0;
        exp_c      = '0;
        exp_flags  = '0;
        -> compare_ev;
        @(negedge clk);
        exp_label  = name;
        exp_halted = 1'b1;
        run_model(exp_a, exp_b, exp_c, exp_flags, exp_pc);
        while (!halted) @(negedge clk);
        repeat (21) begin
            -> compare_ev;                                        // Results must hold while halted
            @(negedge clk);
        end
    endtask

    initial begin
        hold_reset = 1'b1;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;

        // Immediate loads keep the carry from earlier arithmetic
        new_image();
        emit(LDI_A);
        emit(8'h05);
        emit(LDI_B);
        emit(8'h06);
        emit(SUB_B);
        emit(LDI_A);
        emit(8'h00);
        emit(HLT);
        run_program("ldi_a_00");
        new_image();
        emit(LDI_A);
        emit(8'hFF);
        emit(LDI_B);
        emit(8'h01);
        emit(ADD_B);
        emit(LDI_B);
        emit(8'h80);
        emit(HLT);
        run_program("ldi_b_80");
        new_image();
        emit(LDI_A);
        emit(8'h00);
        emit(LDI_C);
        emit(8'h7F);
        emit(HLT);
        run_program("ldi_c_7f");

        for (int p = 0; p < 6; p++) begin
            build_random(48);
            run_program($sformatf("random_%0d", p));
        end

        build_jump(JZ, 8'h00);
        run_program("jz_taken");
        build_jump(JZ, 8'h01);
        run_program("jz_skipped");
        build_jump(JNZ, 8'h01);
        run_program("jnz_taken");
        build_jump(JNZ, 8'h00);
        run_program("jnz_skipped");
        build_jump(JN, 8'h80);
        run_program("jn_taken");
        build_jump(JN, 8'h01);
        run_program("jn_skipped");

        // LDA after a carry reads the data byte at 0x40
        new_image();
        emit(LDI_A);
        emit(8'hFF);
        emit(LDI_B);
        emit(8'h02);
        emit(ADD_B);
        emit(LDA);
        emit(8'h40);
        emit(8'h00);
        emit(HLT);
        image[8'h40] = 8'h85;
        run_program("lda_neg");
        image[8'h40] = 8'h00;
        run_program("lda_zero");

        new_image();
        emit(LDI_B);
        emit(8'h33);
        emit(8'h13);                                              // Unassigned opcode
        emit(LDI_A);
        emit(8'h44);
        emit(HLT);
        run_program("unknown_op");

        $display("checks=%0d errors=%0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+rtl
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/control_unit.sv
rtl/datapath.sv
rtl/program_ram.sv
rtl/cpu_top.sv
dv/clock_gen.sv
dv/cpu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cpu_tb
FILELIST  = vlog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
